/* all.f */
common/rd_pkg.sv
verilog/updown_counter.sv
verilog/stream_fifo.sv
read_engine/rd_cmd_setup.sv
read_engine/rd_ar_issue.sv
read_engine/rd_resp_track.sv
read_engine/axi_read_engine.sv
verif/axi_read_engine_props.sv
verif/tb_axi_read_engine.sv

/* Makefile */
# Verilator build and run of the read engine testbench

VERILATOR ?= verilator
TOP       ?= tb_axi_read_engine
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
SIM_FLAGS ?= +verilator+error+limit+1000

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and check $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS SIM_FLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	-./$(BUILD_DIR)/V$(TOP) $(SIM_FLAGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q -x -F '** PASS **' $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* verif/tb_axi_read_engine.sv */
//////////////////////////////
// Read engine testbench
// Memory responder, reference model, stream checks
//////////////////////////////

module tb_axi_read_engine import rd_pkg::*; ();

  localparam int    NUM_TESTS      = 7;
  localparam int    SEED           = 32'h65d2_2143;
  localparam int    TIMEOUT_MARGIN = 2000;
  localparam data_t DATA_TAG       = 64'h5a00_0000_0000_0000;

  //////////////////////////////
  // Test requests
  //////////////////////////////
  string      test_name [NUM_TESTS] = '{"short", "multi_burst", "unaligned", "exact_2048",
                                        "back_pressure", "b2b_single", "b2b_span"};
  addr_t      test_addr [NUM_TESTS] = '{32'h0001_0000, 32'h0002_0000, 32'h0003_0123,
                                        32'h0004_0000, 32'h0010_0000, 32'h0020_0ff8,
                                        32'h0030_0400};
  xfer_size_t test_size [NUM_TESTS] = '{20'd100, 20'd5000, 20'd300, 20'd2048, 20'd20000,
                                        20'd8, 20'd4100};
  // Stream stall level per test (0 never stalls, 2 stalls half the cycles)
  int         test_bp   [NUM_TESTS] = '{1, 1, 1, 0, 2, 1, 1};

  logic       aclk;
  logic       areset;
  logic       ctrl_start;
  addr_t      ctrl_addr;
  xfer_size_t ctrl_size;
  logic       ctrl_done;
  logic       m_axi_arvalid;
  logic       m_axi_arready;
  addr_t      m_axi_araddr;
  len_t       m_axi_arlen;
  logic       m_axi_rvalid;
  logic       m_axi_rready;
  data_t      m_axi_rdata;
  logic       m_axi_rlast;
  logic       m_axis_tvalid;
  logic       m_axis_tready;
  data_t      m_axis_tdata;
  logic       m_axis_tlast;

  // Expected stream, address requests and done pulses
  data_t exp_data_q [$];
  logic  exp_last_q [$];
  int    exp_beat_test_q [$];
  addr_t exp_araddr_q [$];
  len_t  exp_arlen_q [$];
  int    exp_ar_test_q [$];
  int    exp_bursts_q [$];
  int    exp_done_test_q [$];
  // Memory responder state
  addr_t rsp_addr_q [$];
  len_t  rsp_len_q [$];
  int    rsp_beat = 0;
  integer seed = SEED;
  logic [31:0] rand_word;
  int    bp_level = 0;
  int    bp_now = 0;
  // Checker state
  int    cur_test = 0;
  int    mismatch_count = 0;
  int    other_count = 0;
  int    outstanding = 0;
  int    resp_bursts = 0;
  int    done_test = 0;
  logic  done_due = 1'b0;

  axi_read_engine dut0 (.*);

  initial aclk = 1'b0;
  always #2 aclk = ~aclk;

  //////////////////////////////
  // Reference model
  //////////////////////////////
  // Aligned base, beats rounded up, bursts of 256 then the remainder
  function automatic void expected_beats(int test, addr_t addr, xfer_size_t size);
    addr_t base;
    int    beats;
    int    bursts;
    int    left;
    base   = addr - (addr % addr_t'(BURST_BYTES));
    beats  = (int'(size) + DW_BYTES - 1) / DW_BYTES;
    bursts = (beats + BURST_BEATS - 1) / BURST_BEATS;
    for (int b = 0; b < beats; b++) begin
      exp_data_q.push_back(data_t'(base) + data_t'(b * DW_BYTES) + DATA_TAG);
      exp_last_q.push_back((b % BURST_BEATS == BURST_BEATS - 1) || (b == beats - 1));
      exp_beat_test_q.push_back(test);
    end
    for (int k = 0; k < bursts; k++) begin
      left = beats - k * BURST_BEATS;
      exp_araddr_q.push_back(base + addr_t'(k * BURST_BYTES));
      exp_arlen_q.push_back(len_t'((left > BURST_BEATS ? BURST_BEATS : left) - 1));
      exp_ar_test_q.push_back(test);
    end
    exp_bursts_q.push_back(bursts);
    exp_done_test_q.push_back(test);
  endfunction

  task automatic check_beat(int test, data_t exp_data, logic exp_last,
                            data_t act_data, logic act_last);
    if (exp_data !== act_data || exp_last !== act_last) begin
      mismatch_count++;
      $display("Mismatch %s stream beat: expected %h last %b, actual %h last %b",
               test_name[test], exp_data, exp_last, act_data, act_last);
    end
  endtask

  task automatic check_ar(int test, addr_t exp_addr, len_t exp_len,
                          addr_t act_addr, len_t act_len);
    if (exp_addr !== act_addr || exp_len !== act_len) begin
      mismatch_count++;
      $display("Mismatch %s read address: expected %h len %0d, actual %h len %0d",
               test_name[test], exp_addr, exp_len, act_addr, act_len);
    end
  endtask

  task automatic check_done(int test, logic exp_done, logic act_done);
    if (exp_done !== act_done) begin
      mismatch_count++;
      $display("Mismatch %s ctrl_done: expected %b, actual %b",
               test_name[test], exp_done, act_done);
    end
  endtask

  task automatic check_ready(int test, logic exp_ready, logic act_ready);
    if (exp_ready !== act_ready) begin
      mismatch_count++;
      $display("Mismatch %s rready: expected %b, actual %b",
               test_name[test], exp_ready, act_ready);
    end
  endtask

  task automatic print_error_counts();
    $display("Errors: %0d mismatches, %0d other failures, %0d assertion failures",
             mismatch_count, other_count, dut0.u_props.assert_fails);
  endtask

  //////////////////////////////
  // Memory responder
  //////////////////////////////
  // Samples handshakes at the edge, drives the bus 1 unit later
  always @(posedge aclk) begin
    bp_now = bp_level;
    if (!areset) begin
      if (m_axi_arvalid && m_axi_arready) begin
        rsp_addr_q.push_back(m_axi_araddr);
        rsp_len_q.push_back(m_axi_arlen);
      end
      // rready is always high, so a valid beat is taken
      if (m_axi_rvalid) begin
        if (m_axi_rlast) begin
          void'(rsp_addr_q.pop_front());
          void'(rsp_len_q.pop_front());
          rsp_beat = 0;
        end else begin
          rsp_beat++;
        end
      end
    end
    #1;
    rand_word     = $random(seed);
    m_axi_arready = (rand_word[1:0] != 2'd0);
    m_axis_tready = (int'(rand_word[3:2]) >= bp_now);
    if (rsp_addr_q.size() != 0 && rand_word[5:4] != 2'd0) begin
      m_axi_rvalid = 1'b1;
      m_axi_rdata  = data_t'(rsp_addr_q[0]) + data_t'(rsp_beat * DW_BYTES) + DATA_TAG;
      m_axi_rlast  = (rsp_beat == int'(rsp_len_q[0]));
    end else begin
      m_axi_rvalid = 1'b0;
      m_axi_rlast  = 1'b0;
    end
  end

  //////////////////////////////
  // Comparison
  //////////////////////////////
  always @(posedge aclk) begin
    if (!areset) begin
      // Read data channel never stalls
      check_ready(cur_test, 1'b1, m_axi_rready);
      if (m_axi_arvalid && m_axi_arready) begin
        outstanding++;
        if (exp_araddr_q.size() == 0) begin
          other_count++;
          $display("Read address request %h arrived with none expected", m_axi_araddr);
        end else begin
          check_ar(exp_ar_test_q.pop_front(), exp_araddr_q.pop_front(),
                   exp_arlen_q.pop_front(), m_axi_araddr, m_axi_arlen);
        end
      end
      if (m_axis_tvalid && m_axis_tready) begin
        if (m_axis_tlast) begin
          outstanding--;
        end
        if (exp_data_q.size() == 0) begin
          other_count++;
          $display("Stream beat %h left with none expected", m_axis_tdata);
        end else begin
          check_beat(exp_beat_test_q.pop_front(), exp_data_q.pop_front(),
                     exp_last_q.pop_front(), m_axis_tdata, m_axis_tlast);
        end
      end
      if (outstanding > MAX_OUTSTANDING) begin
        other_count++;
        $display("More than %0d bursts outstanding (%0d)", MAX_OUTSTANDING, outstanding);
      end
      // Done is due the cycle after the final burst's last beat
      check_done(done_test, done_due, ctrl_done);
      done_due = 1'b0;
      if (m_axi_rvalid && m_axi_rlast && exp_bursts_q.size() != 0) begin
        resp_bursts++;
        done_test = exp_done_test_q[0];
        if (resp_bursts == exp_bursts_q[0]) begin
          done_due    = 1'b1;
          resp_bursts = 0;
          void'(exp_bursts_q.pop_front());
          void'(exp_done_test_q.pop_front());
        end
      end
    end
  end

  //////////////////////////////
  // Stimulus
  //////////////////////////////
  initial begin
    areset        = 1'b1;
    ctrl_start    = 1'b0;
    ctrl_addr     = '0;
    ctrl_size     = '0;
    m_axi_arready = 1'b0;
    m_axi_rvalid  = 1'b0;
    m_axi_rdata   = '0;
    m_axi_rlast   = 1'b0;
    m_axis_tready = 1'b0;
    repeat (8) @(posedge aclk);
    #1 areset = 1'b0;
    // Each request starts right after the previous done
    for (int t = 0; t < NUM_TESTS; t++) begin
      @(posedge aclk);
      #1;
      cur_test   = t;
      bp_level   = test_bp[t];
      expected_beats(t, test_addr[t], test_size[t]);
      ctrl_start = 1'b1;
      ctrl_addr  = test_addr[t];
      ctrl_size  = test_size[t];
      @(posedge aclk);
      #1 ctrl_start = 1'b0;
      @(posedge aclk);
      while (!ctrl_done) @(posedge aclk);
    end
    // Drain what is left in the FIFO
    bp_level = 0;
    while (exp_data_q.size() != 0) @(posedge aclk);
    repeat (20) @(posedge aclk);
    if (exp_araddr_q.size() != 0 || exp_bursts_q.size() != 0) begin
      other_count++;
      $display("Read address requests or done pulses still missing at the end");
    end
    print_error_counts();
    if (mismatch_count + other_count + dut0.u_props.assert_fails == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

  // Watchdog allows 8 cycles per beat of all requests plus a margin
  initial begin : watchdog
    int limit;
    limit = TIMEOUT_MARGIN;
    for (int t = 0; t < NUM_TESTS; t++) begin
      limit += 8 * ((int'(test_size[t]) + DW_BYTES - 1) / DW_BYTES);
    end
    repeat (limit) @(posedge aclk);
    other_count++;
    $display("Timeout, the run did not finish within %0d cycles", limit);
    print_error_counts();
    $display("** FAIL **");
    $finish;
  end

endmodule

/* verif/axi_read_engine_props.sv */
//////////////////////////////
// Read engine bus properties
//////////////////////////////

module axi_read_engine_props import rd_pkg::*; (
  input logic  aclk,
  input logic  areset,
  input logic  ctrl_done,
  input logic  m_axi_arvalid,
  input logic  m_axi_arready,
  input addr_t m_axi_araddr,
  input len_t  m_axi_arlen,
  input logic  m_axis_tvalid,
  input logic  m_axis_tready,
  input data_t m_axis_tdata,
  input logic  m_axis_tlast
);

  // Failure tally read by the testbench
  int unsigned assert_fails = 0;

  // Request held until arready
  ar_hold: assert property (@(posedge aclk) disable iff (areset)
    m_axi_arvalid && !m_axi_arready |=>
      m_axi_arvalid && $stable(m_axi_araddr) && $stable(m_axi_arlen))
  else begin
    assert_fails++;
    $error("read address request dropped or changed before arready");
  end

  done_pulse: assert property (@(posedge aclk) disable iff (areset)
    ctrl_done |=> !ctrl_done)
  else begin
    assert_fails++;
    $error("ctrl_done high for more than one cycle");
  end

  // Quiet outputs out of reset
  reset_quiet: assert property (@(posedge aclk)
    areset |=> !m_axi_arvalid && !m_axis_tvalid && !ctrl_done)
  else begin
    assert_fails++;
    $error("valid or done high after reset");
  end

  stream_hold: assert property (@(posedge aclk) disable iff (areset)
    m_axis_tvalid && !m_axis_tready |=>
      m_axis_tvalid && $stable(m_axis_tdata) && $stable(m_axis_tlast))
  else begin
    assert_fails++;
    $error("stream beat dropped or changed under back-pressure");
  end

endmodule

bind axi_read_engine axi_read_engine_props u_props (.*);

/* read_engine/axi_read_engine.sv */
//////////////////////////////
// Read burst engine top
// Setup, address issue, response tracking, stream FIFO
//////////////////////////////

module axi_read_engine import rd_pkg::*; (
  input  logic       aclk,
  input  logic       areset,
  // Control
  input  logic       ctrl_start,
  input  addr_t      ctrl_addr,
  input  xfer_size_t ctrl_size,
  output logic       ctrl_done,
  // Read address channel
  output logic       m_axi_arvalid,
  input  logic       m_axi_arready,
  output addr_t      m_axi_araddr,
  output len_t       m_axi_arlen,
  // Read data channel
  input  logic       m_axi_rvalid,
  output logic       m_axi_rready,
  input  data_t      m_axi_rdata,
  input  logic       m_axi_rlast,
  // Stream output
  output logic       m_axis_tvalid,
  input  logic       m_axis_tready,
  output data_t      m_axis_tdata,
  output logic       m_axis_tlast
);

  logic      go;
  addr_t     base_addr;
  xfer_cnt_t burst_count;
  len_t      final_len;
  logic      burst_retired;
  beat_t     fifo_in;
  beat_t     fifo_out;

  // FIFO holds every outstanding beat, so no read stall
  assign m_axi_rready = 1'b1;

  // Burst slot frees once its last beat leaves the stream
  assign burst_retired = m_axis_tvalid && m_axis_tready && m_axis_tlast;

  assign fifo_in.last  = m_axi_rlast;
  assign fifo_in.data  = m_axi_rdata;
  assign m_axis_tlast  = fifo_out.last;
  assign m_axis_tdata  = fifo_out.data;

  rd_cmd_setup u_setup (
    .aclk        (aclk),
    .areset      (areset),
    .ctrl_start  (ctrl_start),
    .ctrl_addr   (ctrl_addr),
    .ctrl_size   (ctrl_size),
    .go          (go),
    .base_addr   (base_addr),
    .burst_count (burst_count),
    .final_len   (final_len)
  );

  rd_ar_issue u_ar_issue (
    .aclk          (aclk),
    .areset        (areset),
    .go            (go),
    .base_addr     (base_addr),
    .burst_count   (burst_count),
    .final_len     (final_len),
    .burst_retired (burst_retired),
    .m_axi_arvalid (m_axi_arvalid),
    .m_axi_arready (m_axi_arready),
    .m_axi_araddr  (m_axi_araddr),
    .m_axi_arlen   (m_axi_arlen)
  );

  rd_resp_track u_resp_track (
    .aclk         (aclk),
    .areset       (areset),
    .go           (go),
    .burst_count  (burst_count),
    .m_axi_rvalid (m_axi_rvalid),
    .m_axi_rlast  (m_axi_rlast),
    .ctrl_done    (ctrl_done)
  );

  stream_fifo #(
    .item_t (beat_t)
  ) u_fifo (
    .aclk     (aclk),
    .areset   (areset),
    .wr_en    (m_axi_rvalid),
    .wr_item  (fifo_in),
    .rd_ready (m_axis_tready),
    .rd_valid (m_axis_tvalid),
    .rd_item  (fifo_out)
  );

endmodule

/* read_engine/rd_resp_track.sv */
//////////////////////////////
// Read response tracker
// Counts bursts back, pulses done
//////////////////////////////

module rd_resp_track import rd_pkg::*; (
  input  logic      aclk,
  input  logic      areset,
  input  logic      go,
  input  xfer_cnt_t burst_count,
  input  logic      m_axi_rvalid,
  input  logic      m_axi_rlast,
  output logic      ctrl_done
);

  // rready is tied high, so every valid beat is taken
  logic burst_end;
  logic final_burst;

  assign burst_end = m_axi_rvalid && m_axi_rlast;

  // Bursts still to come back after the current one
  updown_counter #(
    .count_t (xfer_cnt_t)
  ) u_resp_cnt (
    .aclk       (aclk),
    .areset     (areset),
    .load       (go),
    .incr       (1'b0),
    .decr       (burst_end),
    .load_value (burst_count),
    .init_value ('0),
    .count      (),
    .is_zero    (final_burst)
  );

  // Single cycle, the count leaves zero on the same edge
  always_ff @(posedge aclk) begin
    if (areset) begin
      ctrl_done <= 1'b0;
    end else begin
      ctrl_done <= burst_end && final_burst;
    end
  end

endmodule

/* read_engine/rd_ar_issue.sv */
//////////////////////////////
// Read address issue
// Burst stepping with an outstanding limit
//////////////////////////////

module rd_ar_issue import rd_pkg::*; (
  input  logic      aclk,
  input  logic      areset,
  input  logic      go,
  input  addr_t     base_addr,
  input  xfer_cnt_t burst_count,
  input  len_t      final_len,
  input  logic      burst_retired,
  output logic      m_axi_arvalid,
  input  logic      m_axi_arready,
  output addr_t     m_axi_araddr,
  output len_t      m_axi_arlen
);

  logic arxfer;
  logic ar_idle;
  logic ar_last_burst;
  logic ar_done;
  logic stall_ar;

  assign arxfer  = m_axi_arvalid && m_axi_arready;
  assign ar_done = ar_last_burst && arxfer;

  //////////////////////////////
  // Request valid
  //////////////////////////////
  // Rises only from low, so each burst sees a fresh stall check
  always_ff @(posedge aclk) begin
    if (areset) begin
      m_axi_arvalid <= 1'b0;
    end else if (!ar_idle && !stall_ar && !m_axi_arvalid) begin
      m_axi_arvalid <= 1'b1;
    end else if (m_axi_arready) begin
      m_axi_arvalid <= 1'b0;
    end
  end

  // Nothing to issue between requests
  always_ff @(posedge aclk) begin
    if (areset) begin
      ar_idle <= 1'b1;
    end else if (go) begin
      ar_idle <= 1'b0;
    end else if (ar_done) begin
      ar_idle <= 1'b1;
    end
  end

  // Next burst address after each transfer
  always_ff @(posedge aclk) begin
    if (go) begin
      m_axi_araddr <= base_addr;
    end else if (arxfer) begin
      m_axi_araddr <= m_axi_araddr + addr_t'(BURST_BYTES);
    end
  end

  // Short length only on the final burst
  assign m_axi_arlen = ar_last_burst ? final_len : len_t'(BURST_BEATS - 1);

  //////////////////////////////
  // Counters
  //////////////////////////////
  // Bursts still to send, zero means this one is the last
  updown_counter #(
    .count_t (xfer_cnt_t)
  ) u_burst_cnt (
    .aclk       (aclk),
    .areset     (areset),
    .load       (go),
    .incr       (1'b0),
    .decr       (arxfer),
    .load_value (burst_count),
    .init_value ('0),
    .count      (),
    .is_zero    (ar_last_burst)
  );

  // Free outstanding slots, a slot returns when its last beat leaves the stream
  updown_counter #(
    .count_t (outst_cnt_t)
  ) u_vacancy_cnt (
    .aclk       (aclk),
    .areset     (areset),
    .load       (1'b0),
    .incr       (burst_retired),
    .decr       (arxfer),
    .load_value ('0),
    .init_value (outst_cnt_t'(MAX_OUTSTANDING)),
    .count      (),
    .is_zero    (stall_ar)
  );

endmodule

/* read_engine/rd_cmd_setup.sv */
//////////////////////////////
// Read command setup
// Beat rounding, alignment and burst split
//////////////////////////////

module rd_cmd_setup import rd_pkg::*; (
  input  logic       aclk,
  input  logic       areset,
  input  logic       ctrl_start,
  input  addr_t      ctrl_addr,
  input  xfer_size_t ctrl_size,
  output logic       go,
  output addr_t      base_addr,
  output xfer_cnt_t  burst_count,
  output len_t       final_len
);

  logic       start_d1;
  addr_t      addr_r;
  total_len_t total_len_r;

  // Start strobe delayed two cycles, gives time for the split
  always_ff @(posedge aclk) begin
    if (areset) begin
      start_d1 <= 1'b0;
      go       <= 1'b0;
    end else begin
      start_d1 <= ctrl_start;
      go       <= start_d1;
    end
  end

  // Request capture
  always_ff @(posedge aclk) begin
    if (ctrl_start) begin
      // Partial beat left over, truncation already rounds up
      if (ctrl_size[LOG_DW_BYTES-1:0] != '0) begin
        total_len_r <= ctrl_size[XFER_W-1:LOG_DW_BYTES];
      end else begin
        total_len_r <= ctrl_size[XFER_W-1:LOG_DW_BYTES] - 1'b1;
      end
      // Down to the burst boundary
      addr_r <= ctrl_addr & ~ADDR_MASK;
    end
  end

  // Remainder beats of the final burst, minus one
  always_ff @(posedge aclk) begin
    final_len <= total_len_r[LOG_BURST_BEATS-1:0];
  end

  // Upper bits count the bursts after the first
  assign burst_count = total_len_r[TOTAL_LEN_W-1:LOG_BURST_BEATS];
  assign base_addr   = addr_r;

endmodule

/* verilog/stream_fifo.sv */
//////////////////////////////
// Stream FIFO
// Synchronous, first word falls through
//////////////////////////////

module stream_fifo import rd_pkg::*; #(
  parameter type item_t = beat_t
) (
  input  logic  aclk,
  input  logic  areset,
  input  logic  wr_en,
  input  item_t wr_item,
  input  logic  rd_ready,
  output logic  rd_valid,
  output item_t rd_item
);

  // Pointers carry one extra wrap bit
  logic [$clog2(FIFO_DEPTH):0]   wr_ptr;
  logic [$clog2(FIFO_DEPTH):0]   rd_ptr;
  logic [$clog2(FIFO_DEPTH)-1:0] wr_idx;
  logic [$clog2(FIFO_DEPTH)-1:0] rd_idx;
  item_t mem [FIFO_DEPTH];
  logic  mem_empty;
  logic  out_free;
  logic  bypass;
  logic  pop;

  assign wr_idx    = wr_ptr[$clog2(FIFO_DEPTH)-1:0];
  assign rd_idx    = rd_ptr[$clog2(FIFO_DEPTH)-1:0];
  assign mem_empty = (wr_ptr == rd_ptr);

  // Output stage can take a new item this cycle
  assign out_free = !rd_valid || rd_ready;
  // Empty memory, write goes straight to the output stage
  assign bypass = wr_en && mem_empty && out_free;
  // Refill the output stage from memory
  assign pop = !mem_empty && out_free;

  //////////////////////////////
  // Storage
  //////////////////////////////
  always_ff @(posedge aclk) begin
    if (wr_en && !bypass) begin
      mem[wr_idx] <= wr_item;
    end
  end

  always_ff @(posedge aclk) begin
    if (areset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (wr_en && !bypass) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  //////////////////////////////
  // Output stage
  //////////////////////////////
  // pop and bypass never coincide, bypass needs empty memory
  always_ff @(posedge aclk) begin
    if (pop) begin
      rd_item <= mem[rd_idx];
    end else if (bypass) begin
      rd_item <= wr_item;
    end
  end

  always_ff @(posedge aclk) begin
    if (areset) begin
      rd_valid <= 1'b0;
    end else if (pop || bypass) begin
      rd_valid <= 1'b1;
    end else if (rd_ready) begin
      rd_valid <= 1'b0;
    end
  end

endmodule

/* verilog/updown_counter.sv */
//////////////////////////////
// Up/down counter
// Loadable, with a zero flag
//////////////////////////////

module updown_counter import rd_pkg::*; #(
  parameter type count_t = xfer_cnt_t
) (
  input  logic   aclk,
  input  logic   areset,
  input  logic   load,
  input  logic   incr,
  input  logic   decr,
  input  count_t load_value,
  input  count_t init_value,
  output count_t count,
  output logic   is_zero
);

  // Load wins; a simultaneous incr and decr cancel out
  always_ff @(posedge aclk) begin
    if (areset) begin
      count <= init_value;
    end else if (load) begin
      count <= load_value;
    end else if (incr && !decr) begin
      count <= count + count_t'(1);
    end else if (decr && !incr) begin
      count <= count - count_t'(1);
    end
  end

  // Plain compare of the current count
  assign is_zero = (count == '0);

endmodule

/* common/rd_pkg.sv */
//////////////////////////////
// Read engine shared package
// Bus widths, burst limits and the payload types
//////////////////////////////

package rd_pkg;

  //////////////////////////////
  // Bus geometry
  //////////////////////////////
  localparam int ADDR_W = 32;
  localparam int DATA_W = 64;
  // Byte count input width
  localparam int XFER_W = 20;
  localparam int DW_BYTES = DATA_W / 8;
  localparam int LOG_DW_BYTES = $clog2(DW_BYTES);

  //////////////////////////////
  // Burst limits
  //////////////////////////////
  // Capped by the 256 beat protocol limit and the 4 KB boundary rule
  localparam int BURST_BEATS = (4096 / DW_BYTES < 256) ? 4096 / DW_BYTES : 256;
  localparam int LOG_BURST_BEATS = $clog2(BURST_BEATS);
  // Address step between bursts, also the alignment granule
  localparam int BURST_BYTES = BURST_BEATS * DW_BYTES;
  localparam int MAX_OUTSTANDING = 4;
  // Room for every beat that may be in flight
  localparam int FIFO_DEPTH = 2 ** $clog2(BURST_BEATS * MAX_OUTSTANDING);

  // Derived counter widths
  localparam int TOTAL_LEN_W = XFER_W - LOG_DW_BYTES;
  localparam int XFER_CNT_W = TOTAL_LEN_W - LOG_BURST_BEATS;
  localparam int OUTST_W = $clog2(MAX_OUTSTANDING + 1);

  //////////////////////////////
  // Types
  //////////////////////////////
  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] data_t;
  typedef logic [XFER_W-1:0] xfer_size_t;
  // Burst length in bus format, beats minus one
  typedef logic [LOG_BURST_BEATS-1:0] len_t;
  typedef logic [TOTAL_LEN_W-1:0] total_len_t;
  typedef logic [XFER_CNT_W-1:0] xfer_cnt_t;
  typedef logic [OUTST_W-1:0] outst_cnt_t;

  // Low address bits cleared to reach a burst boundary
  localparam addr_t ADDR_MASK = addr_t'(BURST_BYTES - 1);

  // FIFO entry, last flag on top of the beat data
  typedef struct packed {
    logic  last;
    data_t data;
  } beat_t;

endpackage
